//--- src/lora_soc_config.svh
// ==============================
// Fixed constants of the LoRa node peripheral block
// Clock assumed 25 MHz so TICK_DIV gives a 1 us tick
// Slot values are 5 bits taken from word address bits 6..2
// ==============================
`ifndef LORA_SOC_CONFIG_SVH
`define LORA_SOC_CONFIG_SVH

// ============================
// Peripheral slots
// ============================
`define SLOT_GPIO_OUT   5'h00   // R/W GPIO output register
`define SLOT_GPIO_IN    5'h01   // R   pin state
`define SLOT_GPIO_SEL   5'h03   // R/W pin function select
`define SLOT_TIMER      5'h0C   // R/W microsecond countdown
`define SLOT_WDT        5'h0D   // R/W watchdog kick and remaining time
`define SLOT_SYSINFO    5'h0F   // R chip info, W soft reset key
`define SLOT_NONE       5'h1F   // Address outside the peripheral window

// Address bits 27..7 and 1..0 must match this for a peripheral access
`define PERIPH_BASE     23'h40_0000

// ============================
// Timing
// ============================
`define TICK_DIV        25      // Clocks per microsecond
`define RESET_HOLD      6'd32   // Cycles the internal reset stays low

// ============================
// System info and soft reset
// ============================
`define SOFT_RESET_KEY  8'hA5
`define CHIP_ID         8'h01
`define CHIP_VERSION    8'h10

// Pin levels with the GPIO select bit clear
// Bit 0 UART TX high, 1 radio reset high, 2 SCL released high, 3 MOSI low
// Bit 4 CS high, 5 SDA released high, 6 SCK low, 7 LED off
`define PIN_IDLE        8'b0011_0111

`endif

//--- src/lora_soc_pkg.sv
// ==============================
// Vector types shared by the design and its testbench
// ==============================
package lora_soc_pkg;

    // Bus data word
    typedef logic [31:0] word_t;

    // Word address from the bus master
    typedef logic [27:0] addr_t;

    // Decoded peripheral slot, 1F means none
    typedef logic [4:0]  slot_t;

    // One bank of eight chip pins
    typedef logic [7:0]  pins_t;

    // Count of 1PPS rising edges
    typedef logic [15:0] pps_count_t;

    typedef logic [5:0]  hold_count_t;   // Reset hold, needs to reach 32
    typedef logic [4:0]  tick_count_t;   // Clock divider for the 1 us tick

endpackage

//--- src/periph_bus_if.sv
// ==============================
// Decoded peripheral bus, combinational from the master side
// A write lasts one cycle and lands on the next rising edge
// ==============================
interface periph_bus_if;

    lora_soc_pkg::slot_t slot;    // Selected slot or 1F
    logic                wr;      // Any byte lane written
    logic                rd;      // Any byte lane read
    lora_soc_pkg::word_t wdata;   // Write data

    // Address decoder drives everything
    modport decoder (
        output slot,
        output wr,
        output rd,
        output wdata
    );

    // Peripherals only listen and match their own slot
    modport periph (
        input slot,
        input wr,
        input rd,
        input wdata
    );

endinterface

//--- src/periph_decode.sv
// ==============================
// Slot decode and read-back mux, both combinational
// Unmapped slots and idle cycles read all ones
// ==============================
`include "lora_soc_config.svh"

module periph_decode (
    input  lora_soc_pkg::addr_t      i_addr,
    input  logic [1:0]               i_write_n,        // Active low lane enables
    input  logic [1:0]               i_read_n,
    input  lora_soc_pkg::word_t      i_wdata,
    periph_bus_if.decoder            bus,
    input  lora_soc_pkg::pins_t      i_gpio_out,
    input  lora_soc_pkg::pins_t      i_gpio_sel,
    input  lora_soc_pkg::pins_t      i_ui_pins,
    input  lora_soc_pkg::pins_t      i_uo_pins,
    input  lora_soc_pkg::word_t      i_timer_count,
    input  lora_soc_pkg::word_t      i_wdt_remaining,
    input  lora_soc_pkg::pps_count_t i_pps_count,
    output lora_soc_pkg::word_t      o_rdata
);

    lora_soc_pkg::word_t slot_rdata;   // Mux result before the read strobe
    logic                in_window;

    // ============================
    // Address decode
    // ============================
    assign in_window  = ({i_addr[27:7], i_addr[1:0]} == `PERIPH_BASE);
    assign bus.slot   = in_window ? i_addr[6:2] : `SLOT_NONE;
    assign bus.wr     = (i_write_n != 2'b11);
    assign bus.rd     = (i_read_n != 2'b11);
    assign bus.wdata  = i_wdata;

    // ============================
    // Read-back mux
    // ============================
    always_comb begin
        slot_rdata = '1;                                  // Dropped or unused slots
        case (bus.slot)
            `SLOT_GPIO_OUT: slot_rdata = {24'h0, i_gpio_out};
            `SLOT_GPIO_IN:  slot_rdata = {16'h0, i_uo_pins, i_ui_pins};  // Outputs in byte 1
            `SLOT_GPIO_SEL: slot_rdata = {24'h0, i_gpio_sel};
            `SLOT_TIMER:    slot_rdata = i_timer_count;
            `SLOT_WDT:      slot_rdata = i_wdt_remaining;
            `SLOT_SYSINFO:  slot_rdata = {i_pps_count, `CHIP_ID, `CHIP_VERSION};
            default:        slot_rdata = '1;
        endcase
    end

    // Bus floats high when nobody reads
    assign o_rdata = bus.rd ? slot_rdata : '1;

endmodule

//--- src/reset_ctrl.sv
// ==============================
// Internal reset from the external pin, soft reset and watchdog
// Both triggers hold the internal reset low for 32+ cycles
// ==============================
`include "lora_soc_config.svh"

module reset_ctrl (
    input  logic          clk,
    input  logic          rst_reg_n,      // External reset, synchronous
    periph_bus_if.periph  bus,
    input  logic          i_wdt_reset,    // One-cycle request from watchdog
    output logic          o_int_rst_n
);

    lora_soc_pkg::hold_count_t hold_cnt;
    logic                      soft_reset;
    logic                      hold_trigger;

    // Key written to the system info slot
    assign soft_reset   = bus.wr && (bus.slot == `SLOT_SYSINFO)
                          && (bus.wdata[7:0] == `SOFT_RESET_KEY);
    assign hold_trigger = soft_reset || i_wdt_reset;

    // ============================
    // Hold counter
    // ============================
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            hold_cnt <= '0;
        end else if (hold_trigger) begin
            hold_cnt <= `RESET_HOLD;                // Retrigger restarts the hold
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // Registered so every block sees a clean edge-aligned reset
    always_ff @(posedge clk) begin
        o_int_rst_n <= rst_reg_n && (hold_cnt == '0);
    end

endmodule

//--- src/timebase_sync.sv
// ==============================
// 1 us tick, 1PPS edge counter and DIO1 synchronizer
// i_pps and i_dio1 are asynchronous pins
// ==============================
`include "lora_soc_config.svh"

module timebase_sync (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_pps,
    input  logic                     i_dio1,
    output logic                     o_tick_1us,
    output lora_soc_pkg::pps_count_t o_pps_count,
    output logic                     o_dio1_sync
);

    lora_soc_pkg::tick_count_t us_div;
    logic [1:0]                pps_sync;   // Two flops, bit 1 is safe
    logic                      pps_prev;
    logic [1:0]                dio1_sync;

    // ============================
    // Microsecond tick
    // ============================
    assign o_tick_1us = (us_div == lora_soc_pkg::tick_count_t'(`TICK_DIV - 1));

    always_ff @(posedge clk) begin
        if (!i_rst_n || o_tick_1us) begin
            us_div <= '0;                    // Wraps every TICK_DIV clocks
        end else begin
            us_div <= us_div + 1'b1;
        end
    end

    // ============================
    // Pin synchronizers and PPS counter
    // ============================
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pps_sync    <= 2'b00;
            pps_prev    <= 1'b0;
            dio1_sync   <= 2'b00;
            o_pps_count <= '0;
        end else begin
            pps_sync  <= {pps_sync[0], i_pps};
            pps_prev  <= pps_sync[1];
            dio1_sync <= {dio1_sync[0], i_dio1};
            if (pps_sync[1] && !pps_prev) begin
                o_pps_count <= o_pps_count + 1'b1;   // Rising edge only
            end
        end
    end

    assign o_dio1_sync = dio1_sync[1];   // Level irq, cleared at the radio

endmodule

//--- src/countdown_timer.sv
// ==============================
// Microsecond countdown with sticky expiry irq
// A write to the timer slot reloads and clears the irq
// ==============================
`include "lora_soc_config.svh"

module countdown_timer (
    input  logic                clk,
    input  logic                i_rst_n,
    periph_bus_if.periph        bus,
    input  logic                i_tick_1us,
    output lora_soc_pkg::word_t o_count,
    output logic                o_irq
);

    logic load;

    assign load = bus.wr && (bus.slot == `SLOT_TIMER);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_count <= '0;
            o_irq   <= 1'b0;
        end else if (load) begin
            o_count <= bus.wdata;       // Load wins over a tick in the same cycle
            o_irq   <= 1'b0;
        end else if (i_tick_1us && (o_count != '0)) begin
            o_count <= o_count - 1'b1;
            // Expiry on the step from 1 to 0
            if (o_count == 32'd1) begin
                o_irq <= 1'b1;
            end
        end
    end

endmodule

//--- src/watchdog.sv
// ==============================
// Watchdog counting microseconds down from each kick
// Kick value 0 disarms it, expiry pulses a reset request
// ==============================
`include "lora_soc_config.svh"

module watchdog (
    input  logic                clk,
    input  logic                i_rst_n,
    periph_bus_if.periph        bus,
    input  logic                i_tick_1us,
    output lora_soc_pkg::word_t o_remaining,
    output logic                o_wdt_reset
);

    logic kick;

    assign kick = bus.wr && (bus.slot == `SLOT_WDT);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_remaining <= '0;                  // Comes up disarmed
            o_wdt_reset <= 1'b0;
        end else begin
            o_wdt_reset <= 1'b0;                // Default is no request
            if (kick) begin
                o_remaining <= bus.wdata;
            end else if (i_tick_1us && (o_remaining != '0)) begin
                o_remaining <= o_remaining - 1'b1;
                if (o_remaining == 32'd1) begin
                    o_wdt_reset <= 1'b1;        // Single cycle pulse
                end
            end
        end
    end

endmodule

//--- src/gpio_pinmux.sv
// ==============================
// GPIO output and select registers with the output pin mux
// A clear select bit shows the pin idle level
// ==============================
`include "lora_soc_config.svh"

module gpio_pinmux (
    input  logic                clk,
    input  logic                i_rst_n,
    periph_bus_if.periph        bus,
    output lora_soc_pkg::pins_t o_gpio_out,
    output lora_soc_pkg::pins_t o_gpio_sel,
    output lora_soc_pkg::pins_t o_uo_out
);

    lora_soc_pkg::pins_t idle_pins;

    assign idle_pins = `PIN_IDLE;

    // ============================
    // Registers
    // ============================
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_gpio_out <= '0;
            o_gpio_sel <= '0;                       // All pins idle
        end else if (bus.wr) begin
            if (bus.slot == `SLOT_GPIO_OUT) begin
                o_gpio_out <= bus.wdata[7:0];
            end
            if (bus.slot == `SLOT_GPIO_SEL) begin
                o_gpio_sel <= bus.wdata[7:0];
            end
        end
    end

    // Per-pin choice between GPIO bit and idle level
    assign o_uo_out = (o_gpio_sel & o_gpio_out) | (~o_gpio_sel & idle_pins);

endmodule

//--- src/lora_soc_top.sv
// ==============================
// Peripheral side of the LoRa node, plain bus ports
// Reads are combinational, writes complete in one cycle
// ui_in bit 0 is radio DIO1, bit 4 is the 1PPS pin
// ==============================
module lora_soc_top (
    input  logic                clk,
    input  logic                rst_reg_n,
    input  lora_soc_pkg::addr_t i_addr,
    input  logic [1:0]          i_write_n,
    input  logic [1:0]          i_read_n,
    input  lora_soc_pkg::word_t i_wdata,
    input  lora_soc_pkg::pins_t i_ui_in,
    output lora_soc_pkg::word_t o_rdata,
    output lora_soc_pkg::pins_t o_uo_out,
    output logic [1:0]          o_irq      // Bit 1 timer, bit 0 DIO1
);

    logic                     int_rst_n;
    logic                     tick_1us;
    logic                     wdt_reset;
    lora_soc_pkg::pps_count_t pps_count;
    lora_soc_pkg::word_t      timer_count;
    lora_soc_pkg::word_t      wdt_remaining;
    lora_soc_pkg::pins_t      gpio_out;
    lora_soc_pkg::pins_t      gpio_sel;

    periph_bus_if u_bus ();

    periph_decode u_decode (
        .i_addr          (i_addr),
        .i_write_n       (i_write_n),
        .i_read_n        (i_read_n),
        .i_wdata         (i_wdata),
        .bus             (u_bus.decoder),
        .i_gpio_out      (gpio_out),
        .i_gpio_sel      (gpio_sel),
        .i_ui_pins       (i_ui_in),
        .i_uo_pins       (o_uo_out),
        .i_timer_count   (timer_count),
        .i_wdt_remaining (wdt_remaining),
        .i_pps_count     (pps_count),
        .o_rdata         (o_rdata)
    );

    reset_ctrl u_reset (
        .clk         (clk),
        .rst_reg_n   (rst_reg_n),
        .bus         (u_bus.periph),
        .i_wdt_reset (wdt_reset),
        .o_int_rst_n (int_rst_n)
    );

    timebase_sync u_timebase (
        .clk         (clk),
        .i_rst_n     (int_rst_n),
        .i_pps       (i_ui_in[4]),
        .i_dio1      (i_ui_in[0]),
        .o_tick_1us  (tick_1us),
        .o_pps_count (pps_count),
        .o_dio1_sync (o_irq[0])
    );

    countdown_timer u_timer (
        .clk        (clk),
        .i_rst_n    (int_rst_n),
        .bus        (u_bus.periph),
        .i_tick_1us (tick_1us),
        .o_count    (timer_count),
        .o_irq      (o_irq[1])
    );

    watchdog u_wdt (
        .clk         (clk),
        .i_rst_n     (int_rst_n),
        .bus         (u_bus.periph),
        .i_tick_1us  (tick_1us),
        .o_remaining (wdt_remaining),
        .o_wdt_reset (wdt_reset)
    );

    gpio_pinmux u_gpio (
        .clk        (clk),
        .i_rst_n    (int_rst_n),
        .bus        (u_bus.periph),
        .o_gpio_out (gpio_out),
        .o_gpio_sel (gpio_sel),
        .o_uo_out   (o_uo_out)
    );

endmodule

//--- tb/lora_soc_checker.sv
// ==============================
// Assertions bound into lora_soc_top
// Watches top pins plus a few internal nets
// Failures also bump a counter the testbench reads
// ==============================
`include "lora_soc_config.svh"

module lora_soc_checker (
    input logic                clk,
    input logic                rst_reg_n,
    input logic                i_int_rst_n,     // Internal reset from reset_ctrl
    input lora_soc_pkg::addr_t i_addr,
    input logic [1:0]          i_write_n,
    input lora_soc_pkg::word_t i_wdata,
    input lora_soc_pkg::pins_t i_ui_in,
    input lora_soc_pkg::pins_t i_uo_out,
    input logic [1:0]          i_irq,
    input lora_soc_pkg::pins_t i_gpio_out,
    input lora_soc_pkg::pins_t i_gpio_sel,
    input lora_soc_pkg::word_t i_timer_count,
    input logic                i_wdt_reset
);

    localparam lora_soc_pkg::pins_t IDLE = `PIN_IDLE;
    localparam logic [22:0]         BASE = `PERIPH_BASE;

    // Word addresses of the slots that matter here
    localparam lora_soc_pkg::addr_t TIMER_ADDR   = {BASE[22:2], `SLOT_TIMER, BASE[1:0]};
    localparam lora_soc_pkg::addr_t SYSINFO_ADDR = {BASE[22:2], `SLOT_SYSINFO, BASE[1:0]};

    int   assert_fail_count = 0;
    logic timer_wr;
    logic key_wr;

    assign timer_wr = (i_write_n != 2'b11) && (i_addr == TIMER_ADDR);
    assign key_wr   = (i_write_n != 2'b11) && (i_addr == SYSINFO_ADDR)
                      && (i_wdata[7:0] == `SOFT_RESET_KEY);   // Soft reset trigger

    // ============================
    // Pin mux and reset effect
    // ============================
    pin_merge: assert property (@(posedge clk) disable iff (!rst_reg_n)
        i_uo_out == ((i_gpio_sel & i_gpio_out) | (~i_gpio_sel & IDLE)))
        else begin
            assert_fail_count++;
            $error("uo_out does not match select merge with idle levels");
        end

    // Trigger at k, internal reset at k+1, registers cleared at k+2
    reset_to_idle: assert property (@(posedge clk) disable iff (!rst_reg_n)
        $past(key_wr || i_wdt_reset, 3) |-> (i_uo_out == IDLE))
        else begin
            assert_fail_count++;
            $error("pins not idle after soft reset or watchdog request");
        end

    // ============================
    // Timer
    // ============================
    timer_irq_clear: assert property (@(posedge clk) disable iff (!i_int_rst_n)
        $past(timer_wr) |-> !i_irq[1])
        else begin
            assert_fail_count++;
            $error("timer irq still set after a timer write");
        end

    timer_no_rise: assert property (@(posedge clk) disable iff (!i_int_rst_n)
        ($past(i_int_rst_n) && !$past(timer_wr))
        |-> (i_timer_count <= $past(i_timer_count)))
        else begin
            assert_fail_count++;
            $error("timer count increased without a write");
        end

    // ============================
    // DIO1
    // ============================
    dio1_delay: assert property (@(posedge clk) disable iff (!i_int_rst_n)
        ($past(i_int_rst_n) && $past(i_int_rst_n, 2))
        |-> (i_irq[0] == $past(i_ui_in[0], 2)))
        else begin
            assert_fail_count++;
            $error("DIO1 irq is not the pin delayed by two cycles");
        end

endmodule

bind lora_soc_top lora_soc_checker u_checker (
    .clk           (clk),
    .rst_reg_n     (rst_reg_n),
    .i_int_rst_n   (int_rst_n),
    .i_addr        (i_addr),
    .i_write_n     (i_write_n),
    .i_wdata       (i_wdata),
    .i_ui_in       (i_ui_in),
    .i_uo_out      (o_uo_out),
    .i_irq         (o_irq),
    .i_gpio_out    (gpio_out),
    .i_gpio_sel    (gpio_sel),
    .i_timer_count (timer_count),
    .i_wdt_reset   (wdt_reset)
);

//--- tb/tb_lora_soc.sv
// ==============================
// Testbench for lora_soc_top, 100 unit clock
// Inputs change on the falling edge, reads sampled mid low phase
// Slot 02 stands in for the dropped UART
// ==============================
`include "lora_soc_config.svh"

module tb_lora_soc;

    localparam int                  SETTLE    = 10;        // Read sample delay
    localparam lora_soc_pkg::pins_t IDLE      = `PIN_IDLE;
    localparam lora_soc_pkg::slot_t SLOT_UART = 5'h02;     // Unmapped now
    localparam lora_soc_pkg::word_t ALL_ONES  = 32'hFFFF_FFFF;

    logic                clk = 1'b0;
    logic                rst_reg_n;
    lora_soc_pkg::addr_t i_addr;
    logic [1:0]          i_write_n;
    logic [1:0]          i_read_n;
    lora_soc_pkg::word_t i_wdata;
    lora_soc_pkg::pins_t i_ui_in;
    lora_soc_pkg::word_t o_rdata;
    lora_soc_pkg::pins_t o_uo_out;
    logic [1:0]          o_irq;

    integer              seed = 32'h1f84;
    int                  err_count = 0;
    int                  timeout_count = 0;
    int                  total_fail;
    int                  cycles;
    lora_soc_pkg::word_t rdata;
    lora_soc_pkg::pins_t gpio_val;
    lora_soc_pkg::pins_t gpio_sel;

    always #50 clk = ~clk;

    lora_soc_top DUT (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .i_addr    (i_addr),
        .i_write_n (i_write_n),
        .i_read_n  (i_read_n),
        .i_wdata   (i_wdata),
        .i_ui_in   (i_ui_in),
        .o_rdata   (o_rdata),
        .o_uo_out  (o_uo_out),
        .o_irq     (o_irq)
    );

    // ============================
    // Bus helpers, called just after a falling edge
    // ============================
    function automatic lora_soc_pkg::addr_t slot_addr(input lora_soc_pkg::slot_t slot);
        logic [22:0] base;
        base = `PERIPH_BASE;
        return {base[22:2], slot, base[1:0]};   // Slot sits in address bits 6..2
    endfunction

    task automatic bus_write(input lora_soc_pkg::slot_t slot, input lora_soc_pkg::word_t data);
        i_addr    = slot_addr(slot);
        i_wdata   = data;
        i_write_n = 2'b00;
        @(negedge clk);                         // Lands on the rising edge between
        i_write_n = 2'b11;
    endtask

    task automatic bus_read(input lora_soc_pkg::addr_t addr, output lora_soc_pkg::word_t data);
        i_addr   = addr;
        i_read_n = 2'b00;
        #SETTLE;
        data = o_rdata;                         // Combinational read data
        @(negedge clk);
        i_read_n = 2'b11;
    endtask

    task automatic check_value(input string name, input lora_soc_pkg::word_t exp,
                               input lora_soc_pkg::word_t act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic read_check(input string name, input lora_soc_pkg::slot_t slot,
                              input lora_soc_pkg::word_t exp);
        lora_soc_pkg::word_t data;
        bus_read(slot_addr(slot), data);
        check_value(name, exp, data);
    endtask

    // Random pins, bit 0 forced so the merge never equals the idle pattern
    task automatic set_gpio_random(output lora_soc_pkg::pins_t val,
                                   output lora_soc_pkg::pins_t sel);
        val    = 8'($random(seed));
        sel    = 8'($random(seed));
        sel[0] = 1'b1;
        val[0] = ~IDLE[0];
        bus_write(`SLOT_GPIO_OUT, {24'h0, val});
        bus_write(`SLOT_GPIO_SEL, {24'h0, sel});
        read_check("gpio_out_readback", `SLOT_GPIO_OUT, {24'h0, val});
        read_check("gpio_sel_readback", `SLOT_GPIO_SEL, {24'h0, sel});
        check_value("pin_merge", {24'h0, (sel & val) | (~sel & IDLE)}, {24'h0, o_uo_out});
    endtask

    // ============================
    // Wait loops, each with its own limit
    // ============================
    task automatic wait_irq(input int bit_idx, input logic level, input int max_cycles,
                            input string name, output int waited);
        waited = 0;
        while ((o_irq[bit_idx] !== level) && (waited < max_cycles)) begin
            @(negedge clk);
            waited++;
        end
        if (o_irq[bit_idx] !== level) begin
            $display("TIMEOUT %s: irq bit %0d never reached %b in %0d cycles",
                     name, bit_idx, level, max_cycles);
            timeout_count++;
        end
    endtask

    task automatic wait_pins_idle(input int max_cycles, input string name, output int waited);
        waited = 0;
        while ((o_uo_out !== IDLE) && (waited < max_cycles)) begin
            @(negedge clk);
            waited++;
        end
        if (o_uo_out !== IDLE) begin
            $display("TIMEOUT %s: output pins never returned to idle in %0d cycles",
                     name, max_cycles);
            timeout_count++;
        end
    endtask

    task automatic wait_int_release(input int max_cycles, input string name);
        int waited;
        waited = 0;
        while ((DUT.int_rst_n !== 1'b1) && (waited < max_cycles)) begin
            @(negedge clk);
            waited++;
        end
        if (DUT.int_rst_n !== 1'b1) begin
            $display("TIMEOUT %s: internal reset still active after %0d cycles",
                     name, max_cycles);
            timeout_count++;
        end
    endtask

    // ============================
    // Stimulus
    // ============================
    initial begin
        rst_reg_n = 1'b0;
        i_addr    = '0;
        i_write_n = 2'b11;
        i_read_n  = 2'b11;
        i_wdata   = '0;
        i_ui_in   = '0;
        repeat (5) @(negedge clk);
        rst_reg_n = 1'b1;
        wait_int_release(10, "power_on_reset");

        // Decode, readback and pin mux
        set_gpio_random(gpio_val, gpio_sel);
        read_check("unmapped_uart", SLOT_UART, ALL_ONES);
        bus_read('0, rdata);                            // Outside the window
        check_value("outside_window", ALL_ONES, rdata);

        // System info and 1PPS counter
        read_check("sysinfo_id", `SLOT_SYSINFO, {16'd0, `CHIP_ID, `CHIP_VERSION});
        for (int i = 0; i < 3; i++) begin
            i_ui_in[4] = 1'b1;                          // Slow edges, six cycles each
            repeat (6) @(negedge clk);
            i_ui_in[4] = 1'b0;
            repeat (6) @(negedge clk);
        end
        read_check("sysinfo_pps", `SLOT_SYSINFO, {16'd3, `CHIP_ID, `CHIP_VERSION});

        // Countdown timer, load 4 expires in the 4th microsecond
        bus_write(`SLOT_TIMER, 32'd4);
        wait_irq(1, 1'b1, 150, "timer_expiry", cycles);
        if ((cycles < 3 * `TICK_DIV + 1) || (cycles > 4 * `TICK_DIV)) begin
            $display("ERROR timer_expiry: expected %0d to %0d cycles, actual %0d",
                     3 * `TICK_DIV + 1, 4 * `TICK_DIV, cycles);
            err_count++;
        end
        read_check("timer_zero", `SLOT_TIMER, 32'd0);
        bus_write(`SLOT_TIMER, 32'd0);
        check_value("timer_irq_clear", 32'd0, {31'd0, o_irq[1]});

        // DIO1 toggles with random gaps
        for (int i = 0; i < 6; i++) begin
            i_ui_in[0] = ~i_ui_in[0];
            wait_irq(0, i_ui_in[0], 4, "dio1_sync", cycles);
            repeat (1 + ($unsigned($random(seed)) % 4)) @(negedge clk);
        end

        // Soft reset by key write
        set_gpio_random(gpio_val, gpio_sel);
        bus_write(`SLOT_SYSINFO, {24'h0, `SOFT_RESET_KEY});
        repeat (2) @(negedge clk);
        check_value("soft_reset_pins", {24'h0, IDLE}, {24'h0, o_uo_out});
        repeat (38) @(negedge clk);
        read_check("soft_reset_sel", `SLOT_GPIO_SEL, 32'd0);
        wait_int_release(10, "soft_reset_release");

        // Watchdog expiry, kick of 2 and then silence
        set_gpio_random(gpio_val, gpio_sel);
        bus_write(`SLOT_WDT, 32'd2);
        wait_pins_idle(100, "watchdog_expiry", cycles);
        wait_int_release(60, "watchdog_release");
        read_check("watchdog_sel", `SLOT_GPIO_SEL, 32'd0);
        read_check("watchdog_disarmed", `SLOT_WDT, 32'd0);

        // Watchdog disarmed by a zero write, settings survive
        set_gpio_random(gpio_val, gpio_sel);
        bus_write(`SLOT_WDT, 32'd3);
        bus_write(`SLOT_WDT, 32'd0);
        repeat (300) @(negedge clk);
        read_check("disarm_gpio_out", `SLOT_GPIO_OUT, {24'h0, gpio_val});
        read_check("disarm_gpio_sel", `SLOT_GPIO_SEL, {24'h0, gpio_sel});
        check_value("disarm_pins", {24'h0, (gpio_sel & gpio_val) | (~gpio_sel & IDLE)},
                    {24'h0, o_uo_out});

        // ============================
        // Summary
        // ============================
        total_fail = err_count + timeout_count + DUT.u_checker.assert_fail_count;
        $display("Summary: %0d value errors, %0d timeouts, %0d assertion failures",
                 err_count, timeout_count, DUT.u_checker.assert_fail_count);
        if (total_fail == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+src
src/lora_soc_pkg.sv
src/periph_bus_if.sv
src/periph_decode.sv
src/reset_ctrl.sv
src/timebase_sync.sv
src/countdown_timer.sv
src/watchdog.sv
src/gpio_pinmux.sv
src/lora_soc_top.sv
tb/lora_soc_checker.sv
tb/tb_lora_soc.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the LoRa peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_lora_soc -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running after assertion errors so the testbench prints its summary
"./$OBJ/sim_tb" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
    echo "Simulation result: pass"
    exit 0
else
    echo "Simulation result: fail"
    exit 1
fi
